// File: common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath widths
`define DATA_WIDTH 16
`define INST_WIDTH 16
`define ADDR_WIDTH 6

// instruction fields
`define OPCODE_WIDTH 4
`define IMM_WIDTH 6
`define NUM_REGISTERS_LOG2 3
`define NUM_REGISTERS 8

// alu and pipeline control
`define ALU_OP_WIDTH 3
`define FORWARD_WIDTH 2
`define MEM_OP_WIDTH 2

// memory depths, in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`endif

// File: common/isa_pkg.sv
`include "cpu_params.svh"

package isa_pkg;

  // layout: opcode[15:12] rs[11:9] rt[8:6] rd[5:3]
  // the low six bits double as immediate and absolute target
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_SLT  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LW   = 4'h6,
    OP_SW   = 4'h7,
    OP_BEQ  = 4'h8,
    OP_BNE  = 4'h9,
    OP_JMP  = 4'ha,
    OP_NOP  = 4'hf
  } opcode_t;

  // register index, eight registers
  typedef logic [`NUM_REGISTERS_LOG2-1:0] reg_idx_t;

  // zero-extended immediate / target field
  typedef logic [`IMM_WIDTH-1:0] imm_t;

  // slt compares as signed
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_t;

endpackage

// File: common/pipe_pkg.sv
`include "cpu_params.svh"

package pipe_pkg;

  // operand source in execute
  typedef enum logic [`FORWARD_WIDTH-1:0] {
    FWD_REG    = 2'd0,
    FWD_MEM_WB = 2'd1,
    FWD_EX_MEM = 2'd2
  } forward_t;

  // data memory access carried down the pipe
  typedef enum logic [`MEM_OP_WIDTH-1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_t;

endpackage

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  input  logic                   prog_we,
  input  logic [`ADDR_WIDTH-1:0] prog_addr,
  input  logic [`INST_WIDTH-1:0] prog_data,
  input  logic                   stall,
  input  logic                   jump_valid,
  input  logic [`ADDR_WIDTH-1:0] jump_target,
  input  logic                   branch_taken,
  input  logic [`ADDR_WIDTH-1:0] branch_target,
  output logic [`INST_WIDTH-1:0] if_id_instruction,
  output logic [`ADDR_WIDTH-1:0] if_id_pc
);
  import isa_pkg::*;

  localparam logic [`INST_WIDTH-1:0] NOP_WORD =
    {OP_NOP, {(`INST_WIDTH-`OPCODE_WIDTH){1'b0}}};

  logic [`INST_WIDTH-1:0] imem [`IMEM_DEPTH];
  logic [`ADDR_WIDTH-1:0] pc;
  logic [`ADDR_WIDTH-1:0] pc_next;

  // program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // branch beats jump beats stall
  always_comb begin
    if (branch_taken) begin
      pc_next = branch_target;
    end else if (jump_valid) begin
      pc_next = jump_target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  ////////////////////
  // pc and if/id
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc                <= '0;
      if_id_instruction <= NOP_WORD;
    end else if (run) begin
      pc <= pc_next;
      if (branch_taken || jump_valid) begin
        if_id_instruction <= NOP_WORD;
      end else if (!stall) begin
        if_id_instruction <= imem[pc];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run && (!stall || branch_taken)) begin
      if_id_pc <= pc;
    end
  end

endmodule

// File: decode/decode_unit.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module decode_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  logic [`INST_WIDTH-1:0]  if_id_instruction,
  input  logic                    branch_taken,
  input  logic                    wb_valid,
  input  isa_pkg::reg_idx_t       wb_reg,
  input  logic [`DATA_WIDTH-1:0]  wb_data,
  output logic                    stall,
  output logic                    jump_valid,
  output logic [`ADDR_WIDTH-1:0]  jump_target,
  output isa_pkg::reg_idx_t       id_ex_rs,
  output isa_pkg::reg_idx_t       id_ex_rt,
  output isa_pkg::reg_idx_t       id_ex_rd,
  output logic [`DATA_WIDTH-1:0]  id_ex_data_1,
  output logic [`DATA_WIDTH-1:0]  id_ex_data_2,
  output logic [`DATA_WIDTH-1:0]  id_ex_immediate,
  output isa_pkg::alu_op_t        id_ex_alu_op,
  output logic                    id_ex_alu_src,
  output logic                    id_ex_reg_dst,
  output pipe_pkg::mem_op_t       id_ex_mem_op,
  output logic                    id_ex_reg_write,
  output logic                    id_ex_beq,
  output logic                    id_ex_bne,
  output logic [`ADDR_WIDTH-1:0]  id_ex_branch_target
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  imm_t     imm;

  logic    reg_write, alu_src, reg_dst, beq, bne, is_jmp;
  logic    uses_rs, uses_rt;
  alu_op_t alu_op;
  mem_op_t mem_op;

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGISTERS];
  logic [`DATA_WIDTH-1:0] data_1, data_2;
  logic                   bubble;

  assign opcode = opcode_t'(if_id_instruction[15:12]);
  assign rs     = if_id_instruction[11:9];
  assign rt     = if_id_instruction[8:6];
  assign rd     = if_id_instruction[5:3];
  assign imm    = if_id_instruction[5:0];

  ////////////////////
  // control decode
  always_comb begin
    reg_write = 1'b0;
    alu_src   = 1'b0;
    reg_dst   = 1'b0;
    beq       = 1'b0;
    bne       = 1'b0;
    is_jmp    = 1'b0;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    alu_op    = ALU_ADD;
    mem_op    = MEM_NONE;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: begin
        reg_write = 1'b1;
        reg_dst   = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        alu_op    = alu_op_t'(opcode[2:0]);
      end
      OP_ADDI: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        uses_rs   = 1'b1;
      end
      OP_LW: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        uses_rs   = 1'b1;
        mem_op    = MEM_LOAD;
      end
      OP_SW: begin
        alu_src = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
        mem_op  = MEM_STORE;
      end
      OP_BEQ, OP_BNE: begin
        beq     = (opcode == OP_BEQ);
        bne     = (opcode == OP_BNE);
        uses_rs = 1'b1;
        uses_rt = 1'b1;
        alu_op  = ALU_SUB;
      end
      OP_JMP: is_jmp = 1'b1;
      // nop and unused codes do nothing
      default: ;
    endcase
  end

  // register file, same-cycle write bypassed to the read
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      regs[wb_reg] <= wb_data;
    end
  end

  assign data_1 = (wb_valid && wb_reg == rs) ? wb_data : regs[rs];
  assign data_2 = (wb_valid && wb_reg == rt) ? wb_data : regs[rt];

  // load-use: loaded register is id_ex_rt
  assign stall = (id_ex_mem_op == MEM_LOAD) &&
                 ((uses_rs && id_ex_rt == rs) || (uses_rt && id_ex_rt == rt));

  assign jump_valid  = is_jmp;
  assign jump_target = imm;

  // flushed, stalled and jump slots enter id/ex empty
  assign bubble = branch_taken || stall || is_jmp;

  ////////////////////
  // id/ex register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex_reg_write <= 1'b0;
      id_ex_mem_op    <= MEM_NONE;
      id_ex_beq       <= 1'b0;
      id_ex_bne       <= 1'b0;
      id_ex_alu_op    <= ALU_ADD;
      id_ex_alu_src   <= 1'b0;
      id_ex_reg_dst   <= 1'b0;
    end else if (run) begin
      id_ex_reg_write <= reg_write && !bubble;
      id_ex_mem_op    <= bubble ? MEM_NONE : mem_op;
      id_ex_beq       <= beq && !bubble;
      id_ex_bne       <= bne && !bubble;
      id_ex_alu_op    <= alu_op;
      id_ex_alu_src   <= alu_src;
      id_ex_reg_dst   <= reg_dst;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      id_ex_rs            <= rs;
      id_ex_rt            <= rt;
      id_ex_rd            <= rd;
      id_ex_data_1        <= data_1;
      id_ex_data_2        <= data_2;
      id_ex_immediate     <= {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm};
      id_ex_branch_target <= imm;
    end
  end

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module execute_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  isa_pkg::reg_idx_t       id_ex_rs,
  input  isa_pkg::reg_idx_t       id_ex_rt,
  input  isa_pkg::reg_idx_t       id_ex_rd,
  input  logic [`DATA_WIDTH-1:0]  id_ex_data_1,
  input  logic [`DATA_WIDTH-1:0]  id_ex_data_2,
  input  logic [`DATA_WIDTH-1:0]  id_ex_immediate,
  input  isa_pkg::alu_op_t        id_ex_alu_op,
  input  logic                    id_ex_alu_src,
  input  logic                    id_ex_reg_dst,
  input  pipe_pkg::mem_op_t       id_ex_mem_op,
  input  logic                    id_ex_reg_write,
  input  logic                    id_ex_beq,
  input  logic                    id_ex_bne,
  input  logic [`ADDR_WIDTH-1:0]  id_ex_branch_target,
  input  logic                    wb_valid,
  input  isa_pkg::reg_idx_t       wb_reg,
  input  logic [`DATA_WIDTH-1:0]  wb_data,
  output logic                    branch_taken,
  output logic [`ADDR_WIDTH-1:0]  branch_target,
  output logic [`DATA_WIDTH-1:0]  ex_mem_alu_result,
  output logic [`DATA_WIDTH-1:0]  ex_mem_store_value,
  output isa_pkg::reg_idx_t       ex_mem_dest,
  output pipe_pkg::mem_op_t       ex_mem_mem_op,
  output logic                    ex_mem_reg_write
);
  import isa_pkg::*;
  import pipe_pkg::*;

  forward_t               forward_a, forward_b;
  logic [`DATA_WIDTH-1:0] operand_a, operand_b;
  logic [`DATA_WIDTH-1:0] alu_b;
  logic [`DATA_WIDTH-1:0] alu_result;
  reg_idx_t               dest;
  logic                   equal;

  // younger result in ex/mem wins over mem/wb
  function automatic forward_t select_source(input reg_idx_t src);
    forward_t sel;
    if (ex_mem_reg_write && ex_mem_dest == src) begin
      sel = FWD_EX_MEM;
    end else if (wb_valid && wb_reg == src) begin
      sel = FWD_MEM_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] pick_operand(
    input forward_t               sel,
    input logic [`DATA_WIDTH-1:0] reg_value
  );
    logic [`DATA_WIDTH-1:0] value;
    case (sel)
      FWD_EX_MEM: value = ex_mem_alu_result;
      FWD_MEM_WB: value = wb_data;
      default:    value = reg_value;
    endcase
    return value;
  endfunction

  ////////////////////
  // operands
  always_comb begin
    forward_a = select_source(id_ex_rs);
    forward_b = select_source(id_ex_rt);
    operand_a = pick_operand(forward_a, id_ex_data_1);
    operand_b = pick_operand(forward_b, id_ex_data_2);
  end

  assign alu_b = id_ex_alu_src ? id_ex_immediate : operand_b;

  always_comb begin
    case (id_ex_alu_op)
      ALU_ADD: alu_result = operand_a + alu_b;
      ALU_SUB: alu_result = operand_a - alu_b;
      ALU_AND: alu_result = operand_a & alu_b;
      ALU_OR:  alu_result = operand_a | alu_b;
      ALU_SLT: begin
        alu_result = ($signed(operand_a) < $signed(alu_b)) ? `DATA_WIDTH'd1 : '0;
      end
      default: alu_result = '0;
    endcase
  end

  // r-type writes rd, the rest write rt
  assign dest = id_ex_reg_dst ? id_ex_rd : id_ex_rt;

  ////////////////////
  // branch resolution
  // compare uses the forwarded rt, never the immediate
  assign equal         = (operand_a == operand_b);
  assign branch_taken  = (id_ex_beq && equal) || (id_ex_bne && !equal);
  assign branch_target = id_ex_branch_target;

  // the two flushed slots behind a taken branch arrive here as bubbles,
  // and the branch itself carries no write, so ex/mem stays clear of them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem_reg_write <= 1'b0;
      ex_mem_mem_op    <= MEM_NONE;
    end else if (run) begin
      ex_mem_reg_write <= id_ex_reg_write;
      ex_mem_mem_op    <= id_ex_mem_op;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      ex_mem_alu_result  <= alu_result;
      ex_mem_store_value <= operand_b;
      ex_mem_dest        <= dest;
    end
  end

endmodule

// File: hw/result_unit.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module result_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  logic [`DATA_WIDTH-1:0]  ex_mem_alu_result,
  input  logic [`DATA_WIDTH-1:0]  ex_mem_store_value,
  input  isa_pkg::reg_idx_t       ex_mem_dest,
  input  pipe_pkg::mem_op_t       ex_mem_mem_op,
  input  logic                    ex_mem_reg_write,
  output logic                    wb_valid,
  output isa_pkg::reg_idx_t       wb_reg,
  output logic [`DATA_WIDTH-1:0]  wb_data,
  output logic                    store_valid,
  output logic [`ADDR_WIDTH-1:0]  store_addr,
  output logic [`DATA_WIDTH-1:0]  store_data
);
  import pipe_pkg::*;

  logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];
  logic [`ADDR_WIDTH-1:0] mem_addr;
  logic [`DATA_WIDTH-1:0] mem_read_data;

  // mem/wb register
  logic                   mem_wb_reg_write;
  logic                   mem_wb_load;
  logic [`DATA_WIDTH-1:0] mem_wb_alu_result;
  logic [`DATA_WIDTH-1:0] mem_wb_mem_data;

  ////////////////////
  // memory access
  // word address from the low alu bits
  assign mem_addr      = ex_mem_alu_result[`ADDR_WIDTH-1:0];
  assign mem_read_data = dmem[mem_addr];

  // a store is reported on the edge it writes
  assign store_valid = run && (ex_mem_mem_op == MEM_STORE);
  assign store_addr  = mem_addr;
  assign store_data  = ex_mem_store_value;

  always_ff @(posedge clk) begin
    if (store_valid) begin
      dmem[mem_addr] <= ex_mem_store_value;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb_reg_write <= 1'b0;
      mem_wb_load      <= 1'b0;
    end else if (run) begin
      mem_wb_reg_write <= ex_mem_reg_write;
      mem_wb_load      <= (ex_mem_mem_op == MEM_LOAD);
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      wb_reg            <= ex_mem_dest;
      mem_wb_alu_result <= ex_mem_alu_result;
      mem_wb_mem_data   <= mem_read_data;
    end
  end

  ////////////////////
  // writeback
  // valid only on an advancing edge, so a paused entry is reported once
  assign wb_valid = run && mem_wb_reg_write;
  assign wb_data  = mem_wb_load ? mem_wb_mem_data : mem_wb_alu_result;

endmodule

// File: hw/processor.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module processor (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  logic                    prog_we,
  input  logic [`ADDR_WIDTH-1:0]  prog_addr,
  input  logic [`INST_WIDTH-1:0]  prog_data,
  // retire_* double as the writeback wires
  output logic                    retire_valid,
  output isa_pkg::reg_idx_t       retire_reg,
  output logic [`DATA_WIDTH-1:0]  retire_data,
  output logic                    store_valid,
  output logic [`ADDR_WIDTH-1:0]  store_addr,
  output logic [`DATA_WIDTH-1:0]  store_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // if/id
  logic [`INST_WIDTH-1:0] if_id_instruction;

  // hazard and redirect
  logic                   stall;
  logic                   jump_valid;
  logic [`ADDR_WIDTH-1:0] jump_target;
  logic                   branch_taken;
  logic [`ADDR_WIDTH-1:0] branch_target;

  // id/ex
  reg_idx_t               id_ex_rs, id_ex_rt, id_ex_rd;
  logic [`DATA_WIDTH-1:0] id_ex_data_1, id_ex_data_2, id_ex_immediate;
  alu_op_t                id_ex_alu_op;
  logic                   id_ex_alu_src, id_ex_reg_dst, id_ex_reg_write;
  logic                   id_ex_beq, id_ex_bne;
  mem_op_t                id_ex_mem_op;
  logic [`ADDR_WIDTH-1:0] id_ex_branch_target;

  // ex/mem
  logic [`DATA_WIDTH-1:0] ex_mem_alu_result, ex_mem_store_value;
  reg_idx_t               ex_mem_dest;
  mem_op_t                ex_mem_mem_op;
  logic                   ex_mem_reg_write;

  ////////////////////
  fetch_unit i_fetch (
    .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
    .stall, .jump_valid, .jump_target, .branch_taken, .branch_target,
    .if_id_instruction,
    // pc of the decode slot, visible for debug only
    .if_id_pc ()
  );

  decode_unit i_decode (
    .clk, .rst_n, .run, .if_id_instruction, .branch_taken,
    .wb_valid (retire_valid), .wb_reg (retire_reg), .wb_data (retire_data),
    .stall, .jump_valid, .jump_target,
    .id_ex_rs, .id_ex_rt, .id_ex_rd, .id_ex_data_1, .id_ex_data_2,
    .id_ex_immediate, .id_ex_alu_op, .id_ex_alu_src, .id_ex_reg_dst,
    .id_ex_mem_op, .id_ex_reg_write, .id_ex_beq, .id_ex_bne,
    .id_ex_branch_target
  );

  execute_unit i_execute (
    .clk, .rst_n, .run,
    .id_ex_rs, .id_ex_rt, .id_ex_rd, .id_ex_data_1, .id_ex_data_2,
    .id_ex_immediate, .id_ex_alu_op, .id_ex_alu_src, .id_ex_reg_dst,
    .id_ex_mem_op, .id_ex_reg_write, .id_ex_beq, .id_ex_bne,
    .id_ex_branch_target,
    .wb_valid (retire_valid), .wb_reg (retire_reg), .wb_data (retire_data),
    .branch_taken, .branch_target,
    .ex_mem_alu_result, .ex_mem_store_value, .ex_mem_dest,
    .ex_mem_mem_op, .ex_mem_reg_write
  );

  result_unit i_result (
    .clk, .rst_n, .run,
    .ex_mem_alu_result, .ex_mem_store_value, .ex_mem_dest,
    .ex_mem_mem_op, .ex_mem_reg_write,
    .wb_valid (retire_valid), .wb_reg (retire_reg), .wb_data (retire_data),
    .store_valid, .store_addr, .store_data
  );

endmodule

// File: bench/isa_model.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

// in-order reference of the instruction set, no pipeline
module isa_model;
  import isa_pkg::*;

  localparam int MAX_EVENTS = 256;
  localparam int MAX_STEPS  = 512;

  logic [`INST_WIDTH-1:0] imem [`IMEM_DEPTH];
  logic [`DATA_WIDTH-1:0] regs [`NUM_REGISTERS];
  logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];

  // expected streams, in program order
  reg_idx_t               wr_reg  [MAX_EVENTS];
  logic [`DATA_WIDTH-1:0] wr_data [MAX_EVENTS];
  int                     wr_count = 0;
  logic [`ADDR_WIDTH-1:0] st_addr [MAX_EVENTS];
  logic [`DATA_WIDTH-1:0] st_data [MAX_EVENTS];
  int                     st_count = 0;

  function automatic void clear_state();
    for (int i = 0; i < `NUM_REGISTERS; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < `DMEM_DEPTH; i++) begin
      dmem[i] = '0;
    end
    wr_count = 0;
    st_count = 0;
  endfunction

  function automatic void write_reg(input reg_idx_t r, input logic [`DATA_WIDTH-1:0] value);
    regs[r]           = value;
    wr_reg[wr_count]  = r;
    wr_data[wr_count] = value;
    wr_count++;
  endfunction

  function automatic void store_word(input logic [`ADDR_WIDTH-1:0] addr,
                                     input logic [`DATA_WIDTH-1:0] value);
    dmem[addr]        = value;
    st_addr[st_count] = addr;
    st_data[st_count] = value;
    st_count++;
  endfunction

  ////////////////////
  // runs from address 0 until the pc leaves the program
  function automatic void execute_program(input int length);
    int                     pc;
    int                     steps;
    logic [`INST_WIDTH-1:0] word;
    opcode_t                op;
    reg_idx_t               rs;
    reg_idx_t               rt;
    reg_idx_t               rd;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] imm;
    logic [`DATA_WIDTH-1:0] sum;
    wr_count = 0;
    st_count = 0;
    pc       = 0;
    steps    = 0;
    while (pc < length && steps < MAX_STEPS) begin
      word = imem[pc];
      op   = opcode_t'(word[15:12]);
      rs   = word[11:9];
      rt   = word[8:6];
      rd   = word[5:3];
      imm  = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, word[5:0]};
      a    = regs[rs];
      b    = regs[rt];
      sum  = a + imm;
      pc   = pc + 1;
      steps++;
      case (op)
        OP_ADD:  write_reg(rd, a + b);
        OP_SUB:  write_reg(rd, a - b);
        OP_AND:  write_reg(rd, a & b);
        OP_OR:   write_reg(rd, a | b);
        OP_SLT:  write_reg(rd, ($signed(a) < $signed(b)) ? `DATA_WIDTH'd1 : `DATA_WIDTH'd0);
        OP_ADDI: write_reg(rt, sum);
        OP_LW:   write_reg(rt, dmem[sum[`ADDR_WIDTH-1:0]]);
        OP_SW:   store_word(sum[`ADDR_WIDTH-1:0], b);
        OP_BEQ:  if (a == b) pc = int'(word[5:0]);
        OP_BNE:  if (a != b) pc = int'(word[5:0]);
        OP_JMP:  pc = int'(word[5:0]);
        default: ;
      endcase
    end
  endfunction

endmodule

// File: bench/processor_tb.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module processor_tb;
  import isa_pkg::*;

  localparam int STREAM_TIMEOUT  = 600;
  localparam int DRAIN_CYCLES    = 8;
  localparam int RANDOM_PROGRAMS = 4;
  localparam int RANDOM_LENGTH   = 30;
  // prologue of one clear and four stores comes first
  localparam int RANDOM_END      = 5 + RANDOM_LENGTH;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   run;
  logic                   prog_we;
  logic [`ADDR_WIDTH-1:0] prog_addr;
  logic [`INST_WIDTH-1:0] prog_data;
  logic                   retire_valid;
  reg_idx_t               retire_reg;
  logic [`DATA_WIDTH-1:0] retire_data;
  logic                   store_valid;
  logic [`ADDR_WIDTH-1:0] store_addr;
  logic [`DATA_WIDTH-1:0] store_data;

  logic [`INST_WIDTH-1:0] program_words [`IMEM_DEPTH];
  int                     program_len;
  int                     retire_ptr;
  int                     store_ptr;
  int                     error_count;
  int                     test_count;
  int                     failed_count;
  int                     test_start_errors;

  logic                   retire_pending;
  logic                   store_pending;
  reg_idx_t               exp_retire_reg;
  logic [`DATA_WIDTH-1:0] exp_retire_data;
  logic [`ADDR_WIDTH-1:0] exp_store_addr;
  logic [`DATA_WIDTH-1:0] exp_store_data;

  processor i_dut (
    .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
    .retire_valid, .retire_reg, .retire_data,
    .store_valid, .store_addr, .store_data
  );

  isa_model i_model ();

  always #20 clk = ~clk;

  ////////////////////
  // stream heads
  assign retire_pending  = (retire_ptr < i_model.wr_count);
  assign store_pending   = (store_ptr < i_model.st_count);
  assign exp_retire_reg  = i_model.wr_reg[retire_ptr[7:0]];
  assign exp_retire_data = i_model.wr_data[retire_ptr[7:0]];
  assign exp_store_addr  = i_model.st_addr[store_ptr[7:0]];
  assign exp_store_data  = i_model.st_data[store_ptr[7:0]];

  always @(posedge clk) begin
    if (!rst_n) begin
      retire_ptr <= 0;
      store_ptr  <= 0;
    end else begin
      if (retire_valid) retire_ptr <= retire_ptr + 1;
      if (store_valid) store_ptr <= store_ptr + 1;
    end
  end

  function automatic void flag_value(input string name,
                                     input logic [`DATA_WIDTH-1:0] expected,
                                     input logic [`DATA_WIDTH-1:0] actual);
    error_count++;
    $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endfunction

  function automatic void flag_failure(input string what);
    error_count++;
    $display("FAILURE at %0t: %s", $time, what);
  endfunction

  ////////////////////
  // report checks
  retire_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_pending)
    else flag_failure("register write reported past the end of the expected stream");
  retire_reg_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && retire_pending |-> retire_reg == exp_retire_reg)
    else flag_value("retire_reg", `DATA_WIDTH'($sampled(exp_retire_reg)),
                    `DATA_WIDTH'($sampled(retire_reg)));
  retire_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && retire_pending |-> retire_data == exp_retire_data)
    else flag_value("retire_data", $sampled(exp_retire_data), $sampled(retire_data));
  store_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
    store_valid |-> store_pending)
    else flag_failure("store reported past the end of the expected stream");
  store_addr_ok: assert property (@(posedge clk) disable iff (!rst_n)
    store_valid && store_pending |-> store_addr == exp_store_addr)
    else flag_value("store_addr", `DATA_WIDTH'($sampled(exp_store_addr)),
                    `DATA_WIDTH'($sampled(store_addr)));
  store_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
    store_valid && store_pending |-> store_data == exp_store_data)
    else flag_value("store_data", $sampled(exp_store_data), $sampled(store_data));
  // reset and pauses
  quiet_when_stopped: assert property (@(posedge clk)
    !run |-> !retire_valid && !store_valid)
    else flag_failure("a report pulsed while run was low");

  ////////////////////
  // program assembly
  function automatic void emit(input opcode_t op, input int rs, input int rt, input int low);
    program_words[program_len] = {op, 3'(rs), 3'(rt), 6'(low)};
    program_len++;
  endfunction

  function automatic void emit_alu(input opcode_t op, input int rd, input int rs, input int rt);
    emit(op, rs, rt, rd * 8);
  endfunction

  function automatic void emit_imm(input opcode_t op, input int rt, input int rs, input int imm);
    emit(op, rs, rt, imm);
  endfunction

  function automatic int random_reg(input int lowest);
    return int'($urandom_range(7, lowest));
  endfunction

  task automatic build_random_program();
    int kind;
    int target;
    program_len = 0;
    emit_alu(OP_SUB, 0, 0, 0);
    // r0 stays zero and serves as the base for memory access
    for (int a = 0; a < 4; a++) begin
      emit_imm(OP_SW, 0, 0, a);
    end
    for (int i = 0; i < RANDOM_LENGTH; i++) begin
      kind   = int'($urandom_range(9, 0));
      target = program_len + 1 + int'($urandom_range(3, 0));
      if (target > RANDOM_END) target = RANDOM_END;
      case (kind)
        0, 1, 2, 3, 4: begin
          emit_alu(opcode_t'(4'(kind)), random_reg(1), random_reg(0), random_reg(0));
        end
        5: emit_imm(OP_ADDI, random_reg(1), random_reg(0), int'($urandom_range(63, 0)));
        6: emit_imm(OP_LW, random_reg(1), 0, int'($urandom_range(3, 0)));
        7: emit_imm(OP_SW, random_reg(0), 0, int'($urandom_range(3, 0)));
        8: begin
          if ($urandom_range(1, 0) == 0) emit(OP_BEQ, random_reg(0), random_reg(0), target);
          else emit(OP_BNE, random_reg(0), random_reg(0), target);
        end
        default: emit(OP_JMP, 0, 0, target);
      endcase
    end
  endtask

  ////////////////////
  // run control
  task automatic load_program();
    logic [`INST_WIDTH-1:0] word;
    @(negedge clk);
    run   = 1'b0;
    rst_n = 1'b0;
    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      // padding nops carry their own address in the unused bits
      if (a < program_len) word = program_words[a];
      else word = {OP_NOP, 6'd0, 6'(a)};
      i_model.imem[a] = word;
      prog_we   = 1'b1;
      prog_addr = `ADDR_WIDTH'(a);
      prog_data = word;
      @(negedge clk);
    end
    prog_we = 1'b0;
    rst_n   = 1'b1;
    i_model.execute_program(program_len);
  endtask

  task automatic wait_for_streams();
    int cycles;
    cycles = 0;
    while ((retire_pending || store_pending) && cycles < STREAM_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (retire_pending || store_pending) begin
      flag_failure("timed out waiting for the expected register writes and stores");
    end
  endtask

  task automatic wait_for_retires(input int count);
    int cycles;
    cycles = 0;
    while (retire_ptr < count && cycles < STREAM_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (retire_ptr < count) flag_failure("timed out waiting for register writes");
  endtask

  task automatic pause_run(input int cycles);
    run = 1'b0;
    repeat (cycles) @(negedge clk);
    run = 1'b1;
  endtask

  task automatic finish_program();
    wait_for_streams();
    repeat (DRAIN_CYCLES) @(negedge clk);
    run = 1'b0;
  endtask

  task automatic run_test(input string name);
    test_start_errors = error_count;
    load_program();
    run = 1'b1;
    finish_program();
    close_test(name);
  endtask

  function automatic void close_test(input string name);
    test_count++;
    if (error_count == test_start_errors) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      failed_count++;
      $display("test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
    end
  endfunction

  initial begin
    void'($urandom(32'h62fc_4d7b));
    rst_n        = 1'b0;
    run          = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    error_count  = 0;
    test_count   = 0;
    failed_count = 0;
    i_model.clear_state();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    test_start_errors = error_count;
    repeat (10) @(negedge clk);
    close_test("reset state");

    // each instruction feeds the next
    program_len = 0;
    for (int r = 0; r < `NUM_REGISTERS; r++) begin
      emit_alu(OP_SUB, r, r, r);
    end
    emit_imm(OP_ADDI, 1, 0, 5);
    emit_imm(OP_ADDI, 2, 1, 9);
    emit_alu(OP_ADD, 3, 2, 1);
    emit_alu(OP_SUB, 4, 3, 2);
    emit_alu(OP_AND, 5, 4, 3);
    emit_alu(OP_OR, 6, 5, 4);
    emit_alu(OP_SLT, 7, 6, 3);
    emit_alu(OP_SLT, 1, 3, 7);
    emit_imm(OP_ADDI, 2, 2, 63);
    emit_alu(OP_SUB, 3, 0, 2);
    emit_alu(OP_SLT, 4, 3, 1);
    run_test("dependence chain");

    program_len = 0;
    emit_imm(OP_ADDI, 1, 0, 12);
    emit_imm(OP_ADDI, 2, 0, 41);
    emit_imm(OP_SW, 2, 1, 3);
    emit_imm(OP_LW, 3, 1, 3);
    emit_alu(OP_ADD, 4, 3, 2);
    emit_imm(OP_SW, 4, 0, 7);
    emit_imm(OP_LW, 5, 0, 7);
    emit_imm(OP_SW, 5, 1, 0);
    emit_imm(OP_LW, 6, 1, 0);
    emit_imm(OP_ADDI, 6, 6, 1);
    run_test("load and store");

    // targets are absolute, see the slot numbers
    program_len = 0;
    emit_imm(OP_ADDI, 1, 0, 3);
    emit_imm(OP_ADDI, 2, 0, 3);
    emit(OP_BEQ, 1, 2, 6);
    emit_imm(OP_ADDI, 3, 0, 1);
    emit_imm(OP_ADDI, 4, 0, 1);
    emit_imm(OP_ADDI, 5, 0, 1);
    emit(OP_BNE, 1, 0, 9);
    emit_imm(OP_ADDI, 3, 0, 2);
    emit_imm(OP_ADDI, 4, 0, 2);
    emit(OP_BEQ, 1, 0, 12);
    emit_imm(OP_ADDI, 3, 0, 7);
    emit_imm(OP_ADDI, 4, 0, 8);
    emit(OP_BNE, 1, 2, 15);
    emit_imm(OP_ADDI, 5, 0, 9);
    emit(OP_JMP, 0, 0, 16);
    emit_imm(OP_ADDI, 6, 0, 1);
    emit_imm(OP_ADDI, 6, 0, 4);
    emit_alu(OP_ADD, 7, 3, 4);
    run_test("branches and jump");

    for (int p = 0; p < RANDOM_PROGRAMS; p++) begin
      build_random_program();
      run_test($sformatf("random program %0d", p));
    end

    program_len = 0;
    emit_alu(OP_SUB, 0, 0, 0);
    for (int i = 0; i < 6; i++) begin
      emit_imm(OP_ADDI, 1, 1, 3);
      emit_alu(OP_ADD, 2, 2, 1);
      emit_imm(OP_SW, 2, 0, i);
      emit_imm(OP_LW, 3, 0, i);
    end
    test_start_errors = error_count;
    load_program();
    run = 1'b1;
    wait_for_retires(4);
    pause_run(7);
    wait_for_retires(10);
    pause_run(5);
    finish_program();
    close_test("pause and resume");

    $display("tests run: %0d, failed: %0d, errors: %0d", test_count, failed_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hw/fetch_unit.sv
decode/decode_unit.sv
execute/execute_unit.sv
hw/result_unit.sv
hw/processor.sv
bench/isa_model.sv
bench/processor_tb.sv

// File: run.sh
#!/bin/sh
# build and run processor_tb with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module processor_tb -o processor_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/processor_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
exit 1
